//--- gba_audio_pkg.sv
package gba_audio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sample and frame geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W    = 16;            // bits per channel sample
    localparam int FRAME_SLOTS = 2 * SAMPLE_W;  // left slots then right slots
    localparam int SLOT_W      = 5;             // covers 0..FRAME_SLOTS-1

    // channel index, left is the upper half of the stereo word
    localparam logic CH_LEFT  = 1'b0;
    localparam logic CH_RIGHT = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // sample types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // one channel, two's complement

    // write view, left in the top 16 bits like {left, right}
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_pair_t;

    // same 32 bits seen two ways
    // half uses an ascending range so half[0] is the upper (left) sample
    // and half[channel] picks the channel directly
    typedef union packed {
        stereo_pair_t     pair;     // filled on capture
        sample_t [0:1]    half;     // read by channel index
    } stereo_word_u;

endpackage

//--- dac_frame_if.sv
`timescale 1ns/1ps

// signals shared by the sequencer, the sample store and the shifter
interface dac_frame_if;

    logic                   load;       // pulse, start of a channel (slot 0 / 16)
    logic                   shift;      // pulse, every other slot boundary
    logic                   channel;    // level, channel of the current slot
    logic                   bck;        // DAC bit clock level
    logic                   ws;         // word select, low = left
    gba_audio_pkg::sample_t sample;     // half of the stored word for channel

    // timing generator
    modport seq (
        output load,
        output shift,
        output channel,
        output bck,
        output ws
    );

    // stereo register, read by channel
    modport store (
        input  channel,
        output sample
    );

    // serializer
    modport shf (
        input  load,
        input  shift,
        input  sample
    );

endinterface

//--- sample_capture.sv
`timescale 1ns/1ps

// input side of the DAC path
// latches a stereo pair whenever the left sample moves, then hands out
// one half of it depending on the channel the sequencer is on
module sample_capture (
    input  logic                   clk16,
    input  logic                   resetn,
    input  gba_audio_pkg::sample_t sound_left_i,    // from the sound core
    input  gba_audio_pkg::sample_t sound_right_i,
    dac_frame_if.store             frame
);

    ////////////////////////////////////////////////////////////////////////////
    // change detect
    ////////////////////////////////////////////////////////////////////////////

    gba_audio_pkg::sample_t       left_q;     // left sample one cycle ago
    gba_audio_pkg::stereo_word_u  word_q;     // stored stereo pair
    logic                         left_chg;   // write enable for word_q

    // a new pair is assumed whenever left moves
    // right alone changing is not a new sample period
    assign left_chg = (sound_left_i != left_q);

    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            left_q <= '0;
        end else begin
            left_q <= sound_left_i;   // plain delay line
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stereo register
    ////////////////////////////////////////////////////////////////////////////

    // single 32-bit word, overwritten in place
    // nothing queues here, a pair that arrives mid frame simply replaces
    // the one being played and the shifter picks it up at the next load
    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            word_q <= '0;                               // silent until first capture
        end else if (left_chg) begin
            word_q.pair.left  <= sound_left_i;          // upper half
            word_q.pair.right <= sound_right_i;         // lower half, taken together
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // combinational, channel already points at the new channel when load fires
    assign frame.sample = word_q.half[frame.channel];

endmodule

//--- bclk_sequencer.sv
`timescale 1ns/1ps

// bit clock and frame timing for the DAC
// bck toggles every HALF_DIV clk16 cycles, each falling edge opens a slot,
// 32 slots per frame, 16 left then 16 right
module bclk_sequencer #(
    parameter int HALF_DIV = 5              // clk16 cycles per bck half period, >= 2
) (
    input  logic      clk16,
    input  logic      resetn,
    dac_frame_if.seq  frame
);

    localparam int DIV_W = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

    ////////////////////////////////////////////////////////////////////////////
    // bit clock divider
    ////////////////////////////////////////////////////////////////////////////

    logic [DIV_W-1:0]                   div_cnt_q;  // position inside a half period
    logic                               bck_q;
    logic                               toggle;     // last cycle of a half period
    logic                               fall_now;   // next edge takes bck low

    assign toggle   = (div_cnt_q == DIV_W'(HALF_DIV - 1));
    assign fall_now = toggle & bck_q;

    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            div_cnt_q <= '0;
            bck_q     <= 1'b0;                  // first toggle is a rise
        end else if (toggle) begin
            div_cnt_q <= '0;
            bck_q     <= ~bck_q;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // slot counter and word select
    ////////////////////////////////////////////////////////////////////////////

    logic [gba_audio_pkg::SLOT_W-1:0]   slot_q;     // slot in progress
    logic [gba_audio_pkg::SLOT_W-1:0]   slot_nxt;   // slot opened by the next fall
    logic                               ws_q;
    logic                               ch_start;   // slot_nxt is 0 or 16

    // wrap at end of frame
    always_comb begin
        if (slot_q == gba_audio_pkg::SLOT_W'(gba_audio_pkg::FRAME_SLOTS - 1)) begin
            slot_nxt = '0;
        end else begin
            slot_nxt = slot_q + 1'b1;
        end
    end

    // low bits zero means first bit of a channel
    assign ch_start = (slot_nxt[gba_audio_pkg::SLOT_W-2:0] == '0);

    // slot parks at the last value out of reset so the first fall opens slot 0.
    // ws is kept as its own register for that reason, it would read high
    // from the parked slot otherwise
    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            slot_q <= gba_audio_pkg::SLOT_W'(gba_audio_pkg::FRAME_SLOTS - 1);
            ws_q   <= 1'b0;
        end else if (fall_now) begin
            slot_q <= slot_nxt;
            ws_q   <= slot_nxt[gba_audio_pkg::SLOT_W-1];    // high for right slots
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shifter strobes
    ////////////////////////////////////////////////////////////////////////////

    logic                               load_q;
    logic                               shift_q;

    // high for the one cycle where bck has just gone low
    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            load_q  <= 1'b0;
            shift_q <= 1'b0;
        end else begin
            load_q  <= fall_now &  ch_start;    // slots 0 and 16
            shift_q <= fall_now & ~ch_start;    // all other slots
        end
    end

    // outputs
    assign frame.bck     = bck_q;
    assign frame.ws      = ws_q;
    assign frame.load    = load_q;
    assign frame.shift   = shift_q;
    assign frame.channel = slot_q[gba_audio_pkg::SLOT_W-1] ? gba_audio_pkg::CH_RIGHT
                                                           : gba_audio_pkg::CH_LEFT;

endmodule

//--- dac_shifter.sv
`timescale 1ns/1ps

// output side, serializes one channel sample MSB first
// load and shift come in the cycle bck has fallen, so the data bit moves
// one clk16 cycle after the fall and is settled long before the next rise
module dac_shifter (
    input  logic        clk16,
    input  logic        resetn,
    dac_frame_if.shf    frame,
    output logic        hp_din_o    // serial data to the DAC
);

    ////////////////////////////////////////////////////////////////////////////
    // shift register
    ////////////////////////////////////////////////////////////////////////////

    gba_audio_pkg::sample_t sr_q;   // MSB is the bit on the wire

    always_ff @(posedge clk16 or negedge resetn) begin
        if (!resetn) begin
            sr_q <= '0;                         // din low until first frame
        end else if (frame.load) begin
            sr_q <= frame.sample;               // new channel, MSB goes out now
        end else if (frame.shift) begin
            // next lower bit, zero fill at the bottom
            sr_q <= {sr_q[gba_audio_pkg::SAMPLE_W-2:0], 1'b0};
        end
    end

    assign hp_din_o = sr_q[gba_audio_pkg::SAMPLE_W-1];

endmodule

//--- gba_audio_dac.sv
`timescale 1ns/1ps

// audio output path, all on clk16
// stereo sample in, I2S-like serial stream out (bck, ws, din)
module gba_audio_dac #(
    parameter int HALF_DIV = 5                      // clk16 cycles per bck half period
) (
    input  logic                   clk16,
    input  logic                   resetn,          // async, active low
    input  gba_audio_pkg::sample_t sound_left_i,    // left channel sample
    input  gba_audio_pkg::sample_t sound_right_i,   // right channel sample
    output logic                   hp_bck_o,        // DAC bit clock
    output logic                   hp_ws_o,         // low = left channel
    output logic                   hp_din_o         // DAC serial data
);

    ////////////////////////////////////////////////////////////////////////////
    // internal frame signals
    ////////////////////////////////////////////////////////////////////////////

    dac_frame_if frame ();

    // sample store
    sample_capture i_sample_capture (
        .clk16          (clk16),
        .resetn         (resetn),
        .sound_left_i   (sound_left_i),
        .sound_right_i  (sound_right_i),
        .frame          (frame)
    );

    // timing
    bclk_sequencer #(
        .HALF_DIV       (HALF_DIV)
    ) i_bclk_sequencer (
        .clk16          (clk16),
        .resetn         (resetn),
        .frame          (frame)
    );

    // serializer
    dac_shifter i_dac_shifter (
        .clk16          (clk16),
        .resetn         (resetn),
        .frame          (frame),
        .hp_din_o       (hp_din_o)
    );

    // bck and ws go straight out, already registered in the sequencer
    assign hp_bck_o = frame.bck;
    assign hp_ws_o  = frame.ws;

endmodule

//--- tb_dac_checker.sv
`timescale 1ns/1ps

// watches the DAC outputs, keeps a capture model of the stereo pair,
// rebuilds each channel word from the serial stream and compares it
// everything is sampled at clk16 rising edges, so values seen here are
// the ones held during the previous clk16 cycle
module tb_dac_checker #(
    parameter int HALF_DIV = 5
) (
    input  logic        clk16,
    input  logic        resetn,
    input  logic [15:0] left_i,         // driven left sample
    input  logic [15:0] right_i,        // driven right sample
    input  logic        bck_i,
    input  logic        ws_i,
    input  logic        din_i,
    output int          err_cnt_o,
    output int          word_cnt_o,     // channel words compared
    output int          frame_cnt_o,    // full frames collected
    output logic [15:0] last_left_o,    // last assembled left word
    output logic [15:0] last_right_o
);

    int          err_cnt   = 0;
    int          word_cnt  = 0;
    int          frame_cnt = 0;
    logic [15:0] last_left;
    logic [15:0] last_right;

    ////////////////////////////////////////////////////////////////////////////
    // model and collection state
    ////////////////////////////////////////////////////////////////////////////

    logic [15:0] mdl_left;      // expected stored pair
    logic [15:0] mdl_right;
    logic [15:0] prev_left;     // left input one cycle ago
    logic [15:0] exp_word;      // expected half, noted at channel start
    logic [15:0] got_word;      // bits collected at rising bck
    logic        bck_prev;
    logic        ws_prev;
    logic        din_prev;
    logic        started;       // first falling bck seen
    int          slot;
    int          run_len;       // cycles at the current bck level
    int          toggles;
    int          ws_rises;      // rising bck edges since the last ws change

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp_v, got_v);
        err_cnt++;
    endtask

    always @(posedge clk16) begin
        if (!resetn) begin
            if ({bck_i, ws_i, din_i} != 3'b000) begin
                report_mismatch("hp_bck_o/hp_ws_o/hp_din_o in reset", 32'h0,
                                {29'h0, bck_i, ws_i, din_i});
            end
            mdl_left  = '0;
            mdl_right = '0;
            prev_left = '0;
            exp_word  = '0;
            got_word  = '0;
            bck_prev  = 1'b0;
            ws_prev   = 1'b0;
            din_prev  = 1'b0;
            started   = 1'b0;
            slot      = 0;
            run_len   = 0;
            toggles   = 0;
            ws_rises  = 0;
        end else begin
            // half period length, first one after reset skipped
            if (bck_i != bck_prev) begin
                if (toggles > 0 && run_len != HALF_DIV) begin
                    report_mismatch("hp_bck_o half period", HALF_DIV, run_len);
                end
                toggles++;
                run_len = 1;
            end else begin
                run_len++;
            end

            // ws moves only with bck low, 16 rises per level
            if (ws_i != ws_prev) begin
                if (bck_i) begin
                    report_mismatch("hp_bck_o at hp_ws_o change", 32'h0, 32'h1);
                end
                if (ws_rises != 16) begin
                    report_mismatch("hp_ws_o rises per level", 16, ws_rises);
                end
                ws_rises = 0;
            end

            if (din_i != din_prev && bck_i) begin
                report_mismatch("hp_bck_o at hp_din_o change", 32'h0, 32'h1);
            end
            if (!started && din_i) begin
                report_mismatch("hp_din_o before first frame", 32'h0, 32'h1);
            end

            ////////////////////////////////////////////////////////////////////
            // falling bck opens a slot
            ////////////////////////////////////////////////////////////////////
            if (bck_prev && !bck_i) begin
                slot    = started ? (slot + 1) % 32 : 0;
                started = 1'b1;
                if (slot == 0) begin
                    exp_word = mdl_left;    // word the shifter loads now
                end else if (slot == 16) begin
                    exp_word = mdl_right;
                end
                if (ws_i != (slot >= 16)) begin
                    report_mismatch("hp_ws_o at slot start", (slot >= 16), ws_i);
                end
            end

            // rising bck, data is stable here
            if (!bck_prev && bck_i) begin
                if (started) begin
                    ws_rises++;                             // the rise before slot 0 is no level
                    got_word[15 - (slot % 16)] = din_i;     // msb first
                    if (ws_i != (slot >= 16)) begin
                        report_mismatch("hp_ws_o at rising hp_bck_o", (slot >= 16), ws_i);
                    end
                    if (slot % 16 == 15) begin
                        if (got_word != exp_word) begin
                            report_mismatch(slot < 16 ? "hp_din_o left word"
                                                      : "hp_din_o right word",
                                            exp_word, got_word);
                        end
                        word_cnt++;
                        if (slot < 16) begin
                            last_left = got_word;
                        end else begin
                            last_right = got_word;
                            frame_cnt++;
                        end
                    end
                end
            end

            // capture rule, a new pair whenever left moves
            if (left_i != prev_left) begin
                mdl_left  = left_i;
                mdl_right = right_i;
            end
            prev_left = left_i;
            bck_prev  = bck_i;
            ws_prev   = ws_i;
            din_prev  = din_i;
        end
    end

    assign err_cnt_o    = err_cnt;
    assign word_cnt_o   = word_cnt;
    assign frame_cnt_o  = frame_cnt;
    assign last_left_o  = last_left;
    assign last_right_o = last_right;

endmodule

//--- tb_gba_audio_dac.sv
`timescale 1ns/1ps

// testbench top for the DAC output path
module tb_gba_audio_dac;

    localparam int          HALF_DIV   = 5;
    localparam int          FRAME_CYC  = 2 * HALF_DIV * 32;    // clk16 cycles per frame
    localparam logic [31:0] SEED       = 32'hbc7e_aec2;
    localparam int          RAND_PAIRS = 24;
    localparam int          STIM_DLY   = 10;                   // ns after rising clk16

    logic        clk16 = 1'b0;
    logic        resetn;
    logic [15:0] sound_left;
    logic [15:0] sound_right;
    logic        hp_bck;
    logic        hp_ws;
    logic        hp_din;

    int          err_cnt;
    int          word_cnt;
    int          frame_cnt;
    logic [15:0] last_left;
    logic [15:0] last_right;

    int          local_err    = 0;      // errors found by the top itself
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          err_mark     = 0;
    int          word_mark    = 0;
    logic [15:0] cur_left     = '0;
    logic [15:0] cur_right    = '0;

    always #50 clk16 = ~clk16;          // 100 ns period

    gba_audio_dac #(
        .HALF_DIV       (HALF_DIV)
    ) i_gba_audio_dac (
        .clk16          (clk16),
        .resetn         (resetn),
        .sound_left_i   (sound_left),
        .sound_right_i  (sound_right),
        .hp_bck_o       (hp_bck),
        .hp_ws_o        (hp_ws),
        .hp_din_o       (hp_din)
    );

    tb_dac_checker #(
        .HALF_DIV       (HALF_DIV)
    ) i_checker (
        .clk16          (clk16),
        .resetn         (resetn),
        .left_i         (sound_left),
        .right_i        (sound_right),
        .bck_i          (hp_bck),
        .ws_i           (hp_ws),
        .din_i          (hp_din),
        .err_cnt_o      (err_cnt),
        .word_cnt_o     (word_cnt),
        .frame_cnt_o    (frame_cnt),
        .last_left_o    (last_left),
        .last_right_o   (last_right)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_pair(input logic [15:0] l, input logic [15:0] r);
        @(posedge clk16);
        #STIM_DLY;
        sound_left  = l;
        sound_right = r;
        cur_left    = l;
        cur_right   = r;
    endtask

    // returns once n more frames are collected
    // polled mid cycle, checker counters are settled by then
    task automatic wait_frames(input int n);
        int start;
        int waited;
        start  = frame_cnt;
        waited = 0;
        while (frame_cnt < start + n) begin
            @(negedge clk16);
            waited++;
            if (waited > (n + 2) * FRAME_CYC) begin
                $display("timeout: no complete frame seen after %0d clk16 cycles", waited);
                $display("TESTS FAILED");
                $finish;
            end
        end
    endtask

    task automatic check_last(input logic [15:0] l, input logic [15:0] r);
        if (last_left !== l) begin
            $display("[ERROR] hp_din_o left word: expected 0x%0h, got 0x%0h", l, last_left);
            local_err++;
        end
        if (last_right !== r) begin
            $display("[ERROR] hp_din_o right word: expected 0x%0h, got 0x%0h", r, last_right);
            local_err++;
        end
    endtask

    // one line per finished test
    task automatic finish_test(input string name);
        int errs;
        int words;
        errs  = err_cnt + local_err - err_mark;
        words = word_cnt - word_mark;
        tests_run++;
        if (words == 0) begin
            $display("test %0d %s: no channel word was compared", tests_run, name);
            errs++;
            local_err++;
        end
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d words, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "bad", words, errs);
        err_mark  = err_cnt + local_err;
        word_mark = word_cnt;
    endtask

    function automatic logic [15:0] other_value(input logic [15:0] v);
        other_value = v ^ (16'($urandom) | 16'h0001);   // never equal to v
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] seed_v;
        logic [31:0] rnd;
        logic [15:0] l;
        logic [15:0] r;
        logic [15:0] old_r;
        int          hold;
        seed_v      = SEED;
        rnd         = $urandom(seed_v);     // seeds the generator once
        resetn      = 1'b0;
        sound_left  = '0;
        sound_right = '0;
        repeat (4) @(posedge clk16);
        #STIM_DLY resetn = 1'b1;

        wait_frames(2);                     // words still zero
        finish_test("reset state");

        wait_frames(2);                     // shape checked throughout
        finish_test("bit clock and frame shape");

        l = other_value(cur_left);
        r = 16'($urandom);
        drive_pair(l, r);
        wait_frames(2);
        check_last(l, r);
        wait_frames(1);
        check_last(l, r);
        finish_test("constant pair");

        old_r = cur_right;
        drive_pair(cur_left, other_value(cur_right));   // right alone moves
        wait_frames(2);
        check_last(cur_left, old_r);
        l = other_value(cur_left);
        r = 16'($urandom);
        drive_pair(l, r);
        wait_frames(2);
        check_last(l, r);
        finish_test("right-only change ignored");

        for (int i = 0; i < RAND_PAIRS; i++) begin
            drive_pair(16'($urandom), 16'($urandom));
            hold = 2 * FRAME_CYC + ($urandom % (2 * FRAME_CYC + 1));
            repeat (hold) @(posedge clk16);
        end
        wait_frames(2);
        finish_test("random sequence");

        $display("summary: %0d tests, %0d bad, %0d words compared, %0d errors",
                 tests_run, tests_failed, word_cnt, err_cnt + local_err);
        if (tests_failed == 0 && err_cnt + local_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- gba_audio_dac.f
gba_audio_pkg.sv
dac_frame_if.sv
sample_capture.sv
bclk_sequencer.sv
dac_shifter.sv
gba_audio_dac.sv
tb_dac_checker.sv
tb_gba_audio_dac.sv

//--- Bender.yml
package:
  name: gba_audio_dac

sources:
  - gba_audio_pkg.sv
  - dac_frame_if.sv
  - sample_capture.sv
  - bclk_sequencer.sv
  - dac_shifter.sv
  - gba_audio_dac.sv
  - target: test
    files:
      - tb_dac_checker.sv
      - tb_gba_audio_dac.sv
